// File: verilog/boot_pkg.sv
package boot_pkg;

	// Bus and pin widths
	typedef logic [15:0] word_t;
	typedef logic [21:0] flash_addr_t;
	typedef logic [17:0] ram_addr_t;

	// Segment lines a to g with bit 0 as a
	typedef logic [6:0] seg_t;
	typedef logic [3:0] nibble_t;

	typedef enum logic [1:0] {
		COPY_IDLE,
		COPY_READ,
		COPY_WRITE,
		COPY_DONE
	} copy_state_t;

	// Shared by the flash read and SRAM write engines
	typedef enum logic [1:0] {
		CYCLE_IDLE,
		CYCLE_ACTIVE,
		CYCLE_FINISH
	} cycle_state_t;

endpackage

// File: verilog/flash_reader.sv
`timescale 1ns/10ps

module flash_reader #(
	parameter int FLASH_WAIT = 3
) (
	input logic clk,
	input logic rst,
	input logic read,
	input boot_pkg::flash_addr_t flash_word_addr,
	input boot_pkg::word_t flash_data,
	output boot_pkg::flash_addr_t flash_addr,
	output logic flash_ce,
	output logic flash_oe,
	output logic ready,
	output boot_pkg::word_t rd_data
);
	import boot_pkg::*;

	localparam int CW = (FLASH_WAIT > 1) ? $clog2(FLASH_WAIT) : 1;

	cycle_state_t state;
	logic [CW-1:0] wait_cnt;
	logic last_wait;

	assign last_wait = (wait_cnt == CW'(FLASH_WAIT - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= CYCLE_IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				CYCLE_IDLE: begin
					if (read) begin
						state <= CYCLE_ACTIVE;
						wait_cnt <= '0;
					end
				end
				CYCLE_ACTIVE: begin
					if (last_wait)
						state <= CYCLE_FINISH;
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				default: state <= CYCLE_IDLE;
			endcase
		end
	end

	// Address latched at the strobe and bus sampled in the last enabled cycle
	always_ff @(posedge clk) begin
		if (state == CYCLE_IDLE && read)
			flash_addr <= flash_word_addr;
		if (state == CYCLE_ACTIVE && last_wait)
			rd_data <= flash_data;
	end

	assign flash_ce = (state != CYCLE_ACTIVE);
	assign flash_oe = (state != CYCLE_ACTIVE);
	assign ready = (state == CYCLE_FINISH);

endmodule

// File: verilog/sram_writer.sv
`timescale 1ns/10ps

module sram_writer #(
	parameter int WRITE_CYCLES = 2
) (
	input logic clk,
	input logic rst,
	input logic write,
	input boot_pkg::ram_addr_t wr_addr,
	input boot_pkg::word_t wr_data,
	output boot_pkg::ram_addr_t ram_addr,
	output boot_pkg::word_t ram_data,
	output logic ram_en,
	output logic ram_we,
	output logic done
);
	import boot_pkg::*;

	localparam int CW = (WRITE_CYCLES > 1) ? $clog2(WRITE_CYCLES) : 1;

	cycle_state_t state;
	logic [CW-1:0] we_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= CYCLE_IDLE;
			we_cnt <= '0;
		end else begin
			case (state)
				CYCLE_IDLE: begin
					if (write) begin
						state <= CYCLE_ACTIVE;
						we_cnt <= '0;
					end
				end
				CYCLE_ACTIVE: begin
					if (we_cnt == CW'(WRITE_CYCLES - 1))
						state <= CYCLE_FINISH;
					else
						we_cnt <= we_cnt + 1'b1;
				end
				default: state <= CYCLE_IDLE;
			endcase
		end
	end

	// Held through the release cycle so the SRAM sees stable address and data
	always_ff @(posedge clk) begin
		if (state == CYCLE_IDLE && write) begin
			ram_addr <= wr_addr;
			ram_data <= wr_data;
		end
	end

	assign ram_en = (state != CYCLE_ACTIVE);
	assign ram_we = (state != CYCLE_ACTIVE);
	assign done = (state == CYCLE_FINISH);

endmodule

// File: verilog/boot_copier.sv
`timescale 1ns/10ps

module boot_copier #(
	parameter boot_pkg::flash_addr_t FLASH_BASE = '0,
	parameter int BOOT_WORDS = 16
) (
	input logic clk,
	input logic rst,
	input logic ready,
	input boot_pkg::word_t rd_data,
	input logic done,
	output logic read,
	output boot_pkg::flash_addr_t flash_word_addr,
	output logic write,
	output boot_pkg::ram_addr_t wr_addr,
	output boot_pkg::word_t wr_data,
	output logic word_taken,
	output logic boot_done
);
	import boot_pkg::*;

	copy_state_t state;
	ram_addr_t index;
	logic last_word;

	assign last_word = (index == ram_addr_t'(BOOT_WORDS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= COPY_IDLE;
			index <= '0;
			read <= 1'b0;
			write <= 1'b0;
		end else begin
			read <= 1'b0;
			write <= 1'b0;
			case (state)
				COPY_IDLE: begin
					read <= 1'b1;
					state <= COPY_READ;
				end
				COPY_READ: begin
					if (ready) begin
						write <= 1'b1;
						state <= COPY_WRITE;
					end
				end
				COPY_WRITE: begin
					if (done) begin
						if (last_word) begin
							state <= COPY_DONE;
						end else begin
							// Next word read issued right after the write completes
							index <= index + 1'b1;
							read <= 1'b1;
							state <= COPY_READ;
						end
					end
				end
				default: state <= COPY_DONE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == COPY_READ && ready)
			wr_data <= rd_data;
	end

	assign flash_word_addr = FLASH_BASE + flash_addr_t'(index);
	assign wr_addr = index;
	assign word_taken = write;
	assign boot_done = (state == COPY_DONE);

endmodule

// File: verilog/boot_display.sv
`timescale 1ns/10ps

module boot_display #(
	parameter int NUM_DIGITS = 2
) (
	input logic clk,
	input logic rst,
	input logic word_taken,
	input boot_pkg::word_t wr_data,
	input boot_pkg::ram_addr_t wr_addr,
	input logic boot_done,
	output boot_pkg::nibble_t [NUM_DIGITS-1:0] digits,
	output boot_pkg::word_t led
);
	import boot_pkg::*;

	word_t checksum;
	word_t digit_src;

	// Wraps modulo 2^16
	always_ff @(posedge clk) begin
		if (rst)
			checksum <= '0;
		else if (word_taken)
			checksum <= checksum + wr_data;
	end

	assign digit_src = boot_done ? checksum : word_t'(wr_addr);

	// Digit 0 carries the least significant nibble
	always_comb begin
		for (int i = 0; i < NUM_DIGITS; i++)
			digits[i] = digit_src[4*i +: 4];
	end

	assign led = checksum;

endmodule

// File: verilog/seg_decoder.sv
`timescale 1ns/10ps

module seg_decoder (
	input boot_pkg::nibble_t digit,
	output boot_pkg::seg_t seg
);

	// Patterns as gfedcba
	always_comb begin
		case (digit)
			4'h0: seg = 7'h3f;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5b;
			4'h3: seg = 7'h4f;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6d;
			4'h6: seg = 7'h7d;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7f;
			4'h9: seg = 7'h6f;
			4'ha: seg = 7'h77;
			4'hb: seg = 7'h7c;
			4'hc: seg = 7'h39;
			4'hd: seg = 7'h5e;
			4'he: seg = 7'h79;
			default: seg = 7'h71;
		endcase
	end

endmodule

// File: verilog/boot_top.sv
`timescale 1ns/10ps

module boot_top #(
	parameter boot_pkg::flash_addr_t FLASH_BASE = '0,
	parameter int BOOT_WORDS = 16,
	parameter int FLASH_WAIT = 3,
	parameter int WRITE_CYCLES = 2,
	parameter int NUM_DIGITS = 2
) (
	input logic clk,
	input logic rst,
	input boot_pkg::word_t flash_data,
	output boot_pkg::flash_addr_t flash_addr,
	output logic flash_ce,
	output logic flash_oe,
	output boot_pkg::ram_addr_t ram_addr,
	output boot_pkg::word_t ram_data,
	output logic ram_en,
	output logic ram_we,
	output boot_pkg::seg_t [NUM_DIGITS-1:0] seg,
	output boot_pkg::word_t led,
	output logic boot_done
);
	import boot_pkg::*;

	// Copier to flash reader
	logic read;
	logic ready;
	flash_addr_t flash_word_addr;
	word_t rd_data;

	// Copier to SRAM writer and display
	logic write;
	logic done;
	logic word_taken;
	ram_addr_t wr_addr;
	word_t wr_data;

	nibble_t [NUM_DIGITS-1:0] digits;

	flash_reader #(
		.FLASH_WAIT(FLASH_WAIT)
	) __flash_reader (
		.clk(clk),
		.rst(rst),
		.read(read),
		.flash_word_addr(flash_word_addr),
		.flash_data(flash_data),
		.flash_addr(flash_addr),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe),
		.ready(ready),
		.rd_data(rd_data)
	);

	sram_writer #(
		.WRITE_CYCLES(WRITE_CYCLES)
	) __sram_writer (
		.clk(clk),
		.rst(rst),
		.write(write),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.ram_addr(ram_addr),
		.ram_data(ram_data),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.done(done)
	);

	boot_copier #(
		.FLASH_BASE(FLASH_BASE),
		.BOOT_WORDS(BOOT_WORDS)
	) __boot_copier (
		.clk(clk),
		.rst(rst),
		.ready(ready),
		.rd_data(rd_data),
		.done(done),
		.read(read),
		.flash_word_addr(flash_word_addr),
		.write(write),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.word_taken(word_taken),
		.boot_done(boot_done)
	);

	boot_display #(
		.NUM_DIGITS(NUM_DIGITS)
	) __boot_display (
		.clk(clk),
		.rst(rst),
		.word_taken(word_taken),
		.wr_data(wr_data),
		.wr_addr(wr_addr),
		.boot_done(boot_done),
		.digits(digits),
		.led(led)
	);

	for (genvar i = 0; i < NUM_DIGITS; i++) begin : digit_gen
		seg_decoder __seg_decoder (
			.digit(digits[i]),
			.seg(seg[i])
		);
	end

endmodule

// File: verification/boot_sva.sv
`timescale 1ns/10ps

module boot_sva (
	input logic clk,
	input logic rst,
	input logic flash_ce,
	input logic flash_oe,
	input logic ram_en,
	input logic ram_we,
	input logic boot_done
);

	// Output enable only inside a chip-enabled cycle
	oe_needs_ce: assert property (@(posedge clk) disable iff (rst) !flash_oe |-> !flash_ce)
		else $error("flash_oe low while flash_ce high");

	we_needs_en: assert property (@(posedge clk) disable iff (rst) !ram_we |-> !ram_en)
		else $error("ram_we low while ram_en high");

	// Flash and SRAM never share a cycle
	one_device: assert property (@(posedge clk) disable iff (rst) !(!flash_ce && !ram_en))
		else $error("flash and SRAM enabled together");

	done_holds: assert property (@(posedge clk) disable iff (rst) boot_done |=> boot_done)
		else $error("boot_done fell without reset");

endmodule

bind boot_top boot_sva protocol_checks (
	.clk(clk),
	.rst(rst),
	.flash_ce(flash_ce),
	.flash_oe(flash_oe),
	.ram_en(ram_en),
	.ram_we(ram_we),
	.boot_done(boot_done)
);

// File: verification/boot_tb.sv
`timescale 1ns/10ps

module boot_tb;
	import boot_pkg::*;

	// Must match the boot_top defaults
	localparam int FLASH_BASE = 0;
	localparam int BOOT_WORDS = 16;
	localparam int FLASH_WAIT = 3;
	localparam int WRITE_CYCLES = 2;
	localparam int NUM_DIGITS = 2;
	localparam int FLASH_DEPTH = 32;
	localparam int NUM_ROWS = 4;
	localparam int WATCHDOG_CYCLES =
		4 * NUM_ROWS * BOOT_WORDS * (FLASH_WAIT + WRITE_CYCLES + 6) + 500;

	typedef enum logic [1:0] {FILL_ZEROS, FILL_ONES, FILL_COUNT, FILL_RANDOM} fill_t;
	typedef struct packed {
		fill_t fill;
		int abort_at;
	} run_row_t;

	// Fill kind and mid-run reset cycle per row
	// A cycle of -1 means no reset
	run_row_t runs [NUM_ROWS] = '{
		'{FILL_ZEROS, -1},
		'{FILL_ONES, 37},
		'{FILL_COUNT, -1},
		'{FILL_RANDOM, 96}
	};

	logic clk;
	logic rst;
	word_t flash_data;
	flash_addr_t flash_addr;
	logic flash_ce;
	logic flash_oe;
	ram_addr_t ram_addr;
	word_t ram_data;
	logic ram_en;
	logic ram_we;
	seg_t [NUM_DIGITS-1:0] seg;
	word_t led;
	logic boot_done;

	word_t flash_mem [FLASH_DEPTH];
	ram_addr_t write_addr [$];
	word_t write_data [$];
	int flash_cycles = 0;
	logic rst_q = 1'b1;
	logic ram_we_prev = 1'b1;

	boot_top DUT (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Flash answers only while both enables are low
	always @(negedge clk) begin
		if (!flash_ce && !flash_oe && flash_addr < FLASH_DEPTH)
			flash_data <= flash_mem[flash_addr];
		else
			flash_data <= 'x;
	end

	always @(posedge clk) rst_q <= rst;

	// SRAM takes the word when ram_we rises outside reset
	always @(negedge clk) begin
		if (!ram_we_prev && ram_we && !rst_q) begin
			write_addr.push_back(ram_addr);
			write_data.push_back(ram_data);
		end
		if (!flash_ce)
			flash_cycles++;
		ram_we_prev = ram_we;
	end

	function automatic seg_t expect_seg(nibble_t d);
		string lit;
		seg_t pattern;
		byte unsigned ch;
		case (d)
			4'h0: lit = "abcdef";
			4'h1: lit = "bc";
			4'h2: lit = "abdeg";
			4'h3: lit = "abcdg";
			4'h4: lit = "bcfg";
			4'h5: lit = "acdfg";
			4'h6: lit = "acdefg";
			4'h7: lit = "abc";
			4'h8: lit = "abcdefg";
			4'h9: lit = "abcdfg";
			4'ha: lit = "abcefg";
			4'hb: lit = "cdefg";
			4'hc: lit = "adef";
			4'hd: lit = "bcdeg";
			4'he: lit = "adefg";
			default: lit = "aefg";
		endcase
		pattern = '0;
		for (int i = 0; i < lit.len(); i++) begin
			ch = lit[i];
			// Letter a is ASCII 0x61
			pattern[ch - 8'h61] = 1'b1;
		end
		return pattern;
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
		assert (got === expected) else begin
			$display("Error: %s = %h, expected %h", name, got, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_cond(bit ok, string what);
		assert (ok) else begin
			$display("%s", what);
			$display("TEST RESULT: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	task automatic check_digits(word_t src);
		for (int i = 0; i < NUM_DIGITS; i++)
			check_value($sformatf("seg[%0d]", i), 32'(seg[i]), 32'(expect_seg(src[4*i +: 4])));
	endtask

	task automatic check_idle_outputs();
		check_value("flash_ce", 32'(flash_ce), 32'd1);
		check_value("flash_oe", 32'(flash_oe), 32'd1);
		check_value("ram_en", 32'(ram_en), 32'd1);
		check_value("ram_we", 32'(ram_we), 32'd1);
		check_value("boot_done", 32'(boot_done), 32'd0);
		check_value("led", 32'(led), 32'd0);
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		@(negedge clk);
		check_idle_outputs();
		repeat (3) @(negedge clk);
		write_addr.delete();
		write_data.delete();
		rst = 1'b0;
		@(negedge clk);
		check_idle_outputs();
	endtask

	task automatic load_image(fill_t kind);
		for (int a = 0; a < FLASH_DEPTH; a++) begin
			case (kind)
				FILL_ZEROS: flash_mem[a] = 16'h0000;
				FILL_ONES: flash_mem[a] = 16'hffff;
				FILL_COUNT: flash_mem[a] = word_t'(a * 'h0123 + 'h0101);
				default: flash_mem[a] = word_t'($urandom);
			endcase
		end
	endtask

	task automatic run_copy(run_row_t row);
		int sum;
		int flash_snap;
		int writes_snap;
		load_image(row.fill);
		apply_reset();
		if (row.abort_at >= 0) begin
			repeat (row.abort_at) @(negedge clk);
			check_cond(!boot_done, "Copy finished before the mid-run reset");
			apply_reset();
		end
		while (!boot_done) begin
			// Write k shows address k while ram_we is low
			if (!ram_we)
				check_digits(word_t'(write_addr.size()));
			@(negedge clk);
		end
		check_value("write count", 32'(write_addr.size()), 32'(BOOT_WORDS));
		sum = 0;
		for (int k = 0; k < BOOT_WORDS; k++) begin
			check_value("ram_addr", 32'(write_addr[k]), 32'(k));
			check_value("ram_data", 32'(write_data[k]), 32'(flash_mem[FLASH_BASE + k]));
			sum = (sum + flash_mem[FLASH_BASE + k]) & 'hffff;
		end
		check_value("led", 32'(led), 32'(sum));
		check_digits(word_t'(sum));
		flash_snap = flash_cycles;
		writes_snap = write_addr.size();
		repeat (8) @(negedge clk);
		check_value("write count", 32'(write_addr.size()), 32'(writes_snap));
		check_value("flash enable cycles", 32'(flash_cycles), 32'(flash_snap));
		check_value("boot_done", 32'(boot_done), 32'd1);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: boot copy did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst = 1'b1;
		flash_data = '0;
		void'($urandom(53320));
		for (int r = 0; r < NUM_ROWS; r++)
			run_copy(runs[r]);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: all.f
verilog/boot_pkg.sv
verilog/flash_reader.sv
verilog/sram_writer.sv
verilog/boot_copier.sv
verilog/boot_display.sv
verilog/seg_decoder.sv
verilog/boot_top.sv
verification/boot_sva.sv
verification/boot_tb.sv

// File: Makefile
TOOL = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = boot_tb
FILELIST = all.f

SOURCES = $(shell grep -v '^+' $(FILELIST))
BIN = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
